/* Makefile */
VERILATOR  ?= verilator
FILELIST   := src.f
TB_TOP     := tb_emg_core
RTL_TOP    := emg_core_top
OBJ_DIR    := obj_dir
COMMON     := --timing --timescale 1ns/1ps
LINT_FLAGS := --lint-only $(COMMON)
SIM_FLAGS  := --binary --assert -Wno-fatal $(COMMON)
PASS_TEXT  := STATUS: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

# build, run, and pass only if the pass line shows up in the output
sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TB_TOP)); echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* rtl/emg_core_top.sv */
`default_nettype none

module emg_core_top (
    input  logic                        ep50trig,
    input  logic                        reset_global,
    // apb3 slave
    input  logic [neuro_pkg::addr_w-1:0] i_paddr,
    input  logic                        i_psel,
    input  logic                        i_penable,
    input  logic                        i_pwrite,
    input  logic [neuro_pkg::data_w-1:0] i_pwdata,
    output logic [neuro_pkg::data_w-1:0] o_prdata,
    output logic                        o_pready,
    output logic                        o_pslverr,
    // short-latency loop, local motor neurons
    input  logic                        i_mn_spike,
    // long-latency loop, from the other board
    input  logic                        i_ll_spike,
    output logic [neuro_pkg::emg_w-1:0]  o_emg,
    output logic                        o_emg_valid
);
    import neuro_pkg::*;

    logic tick;
    logic [idx_w-1:0] win_index;
    logic [cnt_w-1:0] sl_count;
    logic [cnt_w-1:0] ll_count;
    logic count_valid;

    // shared configuration
    neuro_cfg_if cfg_if ();

    host_regs u_host_regs (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .i_paddr       (i_paddr),
        .i_psel        (i_psel),
        .i_penable     (i_penable),
        .i_pwrite      (i_pwrite),
        .i_pwdata      (i_pwdata),
        .o_prdata      (o_prdata),
        .o_pready      (o_pready),
        .o_pslverr     (o_pslverr),
        .i_sl_count    (sl_count),
        .i_ll_count    (ll_count),
        .i_count_valid (count_valid),
        .i_emg         (o_emg),
        .i_index       (win_index),
        .cfg           (cfg_if.host)
    );

    window_timer u_window_timer (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .cfg          (cfg_if.timer),
        .o_tick       (tick),
        .o_index      (win_index)
    );

    spike_counter sl_counter (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .cfg           (cfg_if.counter),
        .i_spike       (i_mn_spike),
        .i_tick        (tick),
        .o_count       (sl_count),
        .o_count_valid (count_valid)
    );

    // same tick and timing as sl_counter, its valid is redundant
    spike_counter ll_counter (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .cfg           (cfg_if.counter),
        .i_spike       (i_ll_spike),
        .i_tick        (tick),
        .o_count       (ll_count),
        .o_count_valid ()
    );

    emg_filter u_emg_filter (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .cfg          (cfg_if.filter),
        .i_sl_count   (sl_count),
        .i_ll_count   (ll_count),
        .i_valid      (count_valid),
        .o_emg        (o_emg),
        .o_emg_valid  (o_emg_valid)
    );

endmodule

`default_nettype wire

/* rtl/emg_filter.sv */
`default_nettype none

module emg_filter (
    input  logic                       ep50trig,
    input  logic                       reset_global,
    neuro_cfg_if.filter                cfg,
    input  logic [neuro_pkg::cnt_w-1:0] i_sl_count,
    input  logic [neuro_pkg::cnt_w-1:0] i_ll_count,
    input  logic                       i_valid,
    output logic [neuro_pkg::emg_w-1:0] o_emg,
    output logic                       o_emg_valid
);
    import neuro_pkg::*;

    logic [sum_w-1:0] count_sum;
    logic [drive_w-1:0] drive;
    logic [emg_w-1:0] leak;
    logic [emg_w-1:0] emg_kept;
    logic [acc_w-1:0] emg_next;
    logic [emg_w-1:0] emg_sat;

    ////////////////////////////////////////
    // drive term
    ////////////////////////////////////////

    // short plus long latency counts
    assign count_sum = sum_w'(i_sl_count) + sum_w'(i_ll_count);
    // max 510 * 255, fits drive_w
    assign drive = drive_w'(count_sum) * drive_w'(cfg.gain);

    ////////////////////////////////////////
    // leaky integrator
    ////////////////////////////////////////

    // first-order decay, shift of 0 empties the integrator
    assign leak = o_emg >> cfg.leak_shift;
    // never underflows, leak <= o_emg
    assign emg_kept = o_emg - leak;
    assign emg_next = acc_w'(emg_kept) + acc_w'(drive);

    // clip to the top of the emg range
    assign emg_sat = emg_next[acc_w-1] ? emg_max : emg_next[emg_w-1:0];

    always_ff @(posedge ep50trig)
    begin
        if (reset_global || !cfg.enable)
        begin
            // disabled run restarts from zero
            o_emg <= '0;
            o_emg_valid <= 1'b0;
        end
        else
        begin
            // one update per window, on the edge closing the valid pulse
            o_emg_valid <= i_valid;
            if (i_valid)
                o_emg <= emg_sat;
        end
    end

endmodule

`default_nettype wire

/* rtl/host_regs.sv */
`default_nettype none

module host_regs (
    input  logic                        ep50trig,
    input  logic                        reset_global,
    // apb3 slave
    input  logic [neuro_pkg::addr_w-1:0] i_paddr,
    input  logic                        i_psel,
    input  logic                        i_penable,
    input  logic                        i_pwrite,
    input  logic [neuro_pkg::data_w-1:0] i_pwdata,
    output logic [neuro_pkg::data_w-1:0] o_prdata,
    output logic                        o_pready,
    output logic                        o_pslverr,
    // results from the datapath
    input  logic [neuro_pkg::cnt_w-1:0]  i_sl_count,
    input  logic [neuro_pkg::cnt_w-1:0]  i_ll_count,
    input  logic                        i_count_valid,
    input  logic [neuro_pkg::emg_w-1:0]  i_emg,
    input  logic [neuro_pkg::idx_w-1:0]  i_index,
    neuro_cfg_if.host                   cfg
);
    import neuro_pkg::*;

    reg_addr_e addr;
    logic access;
    logic addr_hit;
    logic read_only;
    logic wr_ok;

    // writable registers
    logic ctrl_en;
    logic [win_w-1:0] window_q;
    logic [gain_w-1:0] gain_q;
    logic [shift_w-1:0] leak_q;

    // counts captured once per window
    logic [cnt_w-1:0] sl_count_q;
    logic [cnt_w-1:0] ll_count_q;

    ////////////////////////////////////////
    // apb decode
    ////////////////////////////////////////

    assign addr = reg_addr_e'(i_paddr);
    // access phase, zero wait states
    assign access = i_psel & i_penable;
    assign o_pready = 1'b1;

    // readback mux and address classification
    always_comb
    begin
        o_prdata = '0;
        addr_hit = 1'b1;
        read_only = 1'b0;
        case (addr)
            reg_ctrl:     o_prdata = data_w'(ctrl_en);
            reg_window:   o_prdata = data_w'(window_q);
            reg_gain:     o_prdata = data_w'(gain_q);
            reg_leak:     o_prdata = data_w'(leak_q);
            reg_sl_count:
            begin
                o_prdata = data_w'(sl_count_q);
                read_only = 1'b1;
            end
            reg_ll_count:
            begin
                o_prdata = data_w'(ll_count_q);
                read_only = 1'b1;
            end
            // live values, held by the filter and timer between windows
            reg_emg:
            begin
                o_prdata = data_w'(i_emg);
                read_only = 1'b1;
            end
            reg_index:
            begin
                o_prdata = data_w'(i_index);
                read_only = 1'b1;
            end
            default:      addr_hit = 1'b0;
        endcase
    end

    // unmapped, or a write to a status register
    assign o_pslverr = access & (~addr_hit | (i_pwrite & read_only));
    assign wr_ok = access & i_pwrite & addr_hit & ~read_only;

    ////////////////////////////////////////
    // register file
    ////////////////////////////////////////

    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            ctrl_en <= 1'b0;
            window_q <= window_rst;
            gain_q <= gain_rst;
            leak_q <= leak_rst;
        end
        else if (wr_ok)
        begin
            // write lands on the edge closing the access phase
            case (addr)
                reg_ctrl:   ctrl_en <= i_pwdata[0];
                reg_window: window_q <= i_pwdata[win_w-1:0];
                reg_gain:   gain_q <= i_pwdata[gain_w-1:0];
                reg_leak:   leak_q <= i_pwdata[shift_w-1:0];
                default:    ;
            endcase
        end
    end

    // both counters report in the same cycle
    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            sl_count_q <= '0;
            ll_count_q <= '0;
        end
        else if (i_count_valid)
        begin
            sl_count_q <= i_sl_count;
            ll_count_q <= i_ll_count;
        end
    end

    // configuration out to the datapath
    assign cfg.enable = ctrl_en;
    assign cfg.window_len = window_q;
    assign cfg.gain = gain_q;
    assign cfg.leak_shift = leak_q;

endmodule

`default_nettype wire

/* rtl/neuro_cfg_if.sv */
`default_nettype none

interface neuro_cfg_if;
    import neuro_pkg::*;

    // global run enable, ctrl bit 0
    logic enable;
    // window period is window_len + 1 cycles
    logic [win_w-1:0] window_len;
    // emg drive gain
    logic [gain_w-1:0] gain;
    // leak as a right shift of the integrator
    logic [shift_w-1:0] leak_shift;

    // register block drives everything
    modport host (output enable, output window_len, output gain, output leak_shift);
    modport timer (input enable, input window_len);
    modport counter (input enable);
    modport filter (input enable, input gain, input leak_shift);

endinterface

`default_nettype wire

/* rtl/neuro_pkg.sv */
`default_nettype none

package neuro_pkg;

    ////////////////////////////////////////
    // bus and datapath widths
    ////////////////////////////////////////

    // apb address and data
    localparam int addr_w = 8;
    localparam int data_w = 32;

    // window length register, in clock cycles minus one
    localparam int win_w = 16;

    // per-window spike count, saturates at all ones
    localparam int cnt_w = 8;

    // gain and leak shift coefficients
    localparam int gain_w = 8;
    localparam int shift_w = 4;

    // emg output, unsigned and saturating
    localparam int emg_w = 18;

    // completed-window index, wraps
    localparam int idx_w = 16;

    // emg datapath intermediates
    // sum of two counts needs one extra bit
    localparam int sum_w = cnt_w + 1;
    localparam int drive_w = sum_w + gain_w;
    // one guard bit above emg for the overflow check
    localparam int acc_w = emg_w + 1;

    // saturation limits
    localparam logic [cnt_w-1:0] cnt_max = '1;
    localparam logic [emg_w-1:0] emg_max = '1;

    ////////////////////////////////////////
    // register map
    ////////////////////////////////////////

    // byte addresses, upper four are read-only
    typedef enum logic [addr_w-1:0] {
        reg_ctrl     = 8'h00,
        reg_window   = 8'h04,
        reg_gain     = 8'h08,
        reg_leak     = 8'h0C,
        reg_sl_count = 8'h10,
        reg_ll_count = 8'h14,
        reg_emg      = 8'h18,
        reg_index    = 8'h1C
    } reg_addr_e;

    // register reset values
    localparam logic [win_w-1:0] window_rst = 16'd99;
    localparam logic [gain_w-1:0] gain_rst = 8'd1;
    localparam logic [shift_w-1:0] leak_rst = 4'd2;

endpackage

`default_nettype wire

/* rtl/spike_counter.sv */
`default_nettype none

module spike_counter (
    input  logic                       ep50trig,
    input  logic                       reset_global,
    neuro_cfg_if.counter               cfg,
    input  logic                       i_spike,
    input  logic                       i_tick,
    output logic [neuro_pkg::cnt_w-1:0] o_count,
    output logic                       o_count_valid
);
    import neuro_pkg::*;

    // two-stage synchronizer plus one stage for edge detect
    logic [2:0] spk_q;
    logic spk_rise;

    logic [cnt_w-1:0] run_cnt;
    logic [cnt_w-1:0] run_next;
    // tick seen last cycle, count is already latched
    logic latched_q;

    assign spk_rise = spk_q[1] & ~spk_q[2];

    // saturating increment at 255
    assign run_next = (spk_rise && (run_cnt != cnt_max)) ? run_cnt + cnt_w'(1) : run_cnt;

    // sync chain keeps sampling while disabled
    // so a line already high at enable is not seen as an edge
    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
            spk_q <= '0;
        else
            spk_q <= {spk_q[1:0], i_spike};
    end

    always_ff @(posedge ep50trig)
    begin
        if (reset_global || !cfg.enable)
        begin
            run_cnt <= '0;
            o_count <= '0;
            latched_q <= 1'b0;
            o_count_valid <= 1'b0;
        end
        else
        begin
            latched_q <= i_tick;
            // output settles one cycle before valid
            o_count_valid <= latched_q;
            if (i_tick)
            begin
                // tick cycle edge goes into this window
                o_count <= run_next;
                run_cnt <= '0;
            end
            else
            begin
                run_cnt <= run_next;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/window_timer.sv */
`default_nettype none

module window_timer (
    input  logic                        ep50trig,
    input  logic                        reset_global,
    neuro_cfg_if.timer                  cfg,
    output logic                        o_tick,
    output logic [neuro_pkg::idx_w-1:0]  o_index
);
    import neuro_pkg::*;

    // cycle position inside the current window
    logic [win_w-1:0] cyc_cnt;
    logic last_cyc;

    // last cycle of the window, also catches a shortened window_len
    assign last_cyc = (cyc_cnt >= cfg.window_len);
    assign o_tick = cfg.enable & last_cyc;

    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            cyc_cnt <= '0;
            o_index <= '0;
        end
        else if (!cfg.enable)
        begin
            // idle, next enable starts a fresh window
            cyc_cnt <= '0;
            o_index <= '0;
        end
        else if (last_cyc)
        begin
            cyc_cnt <= '0;
            // completed windows, wraps at idx_w
            o_index <= o_index + idx_w'(1);
        end
        else
        begin
            cyc_cnt <= cyc_cnt + win_w'(1);
        end
    end

endmodule

`default_nettype wire

/* src.f */
rtl/neuro_pkg.sv
rtl/neuro_cfg_if.sv
rtl/host_regs.sv
rtl/window_timer.sv
rtl/spike_counter.sv
rtl/emg_filter.sv
rtl/emg_core_top.sv
test/emg_core_assert.sv
test/tb_emg_core.sv

/* test/emg_core_assert.sv */
`default_nettype none

module emg_core_assert (
    input  logic ep50trig,
    input  logic reset_global,
    // apb handshake of the slave
    input  logic i_psel,
    input  logic i_penable,
    input  logic i_pready,
    input  logic i_pslverr,
    // single-cycle strobes
    input  logic i_pulse_a,
    input  logic i_pulse_b
);
    timeunit 1ns;
    timeprecision 1ps;

    ////////////////////////////////////////
    // apb
    ////////////////////////////////////////

    // zero wait states, ready in every access phase
    ready_in_access: assert property (@(posedge ep50trig) disable iff (reset_global)
        (i_psel && i_penable) |-> i_pready)
    else
        $error("o_pready low during an apb access phase");

    // slave error only inside an access phase
    slverr_in_access: assert property (@(posedge ep50trig) disable iff (reset_global)
        i_pslverr |-> (i_psel && i_penable))
    else
        $error("o_pslverr high outside an apb access phase");

    ////////////////////////////////////////
    // strobes
    ////////////////////////////////////////

    pulse_a_single: assert property (@(posedge ep50trig) disable iff (reset_global)
        i_pulse_a |=> !i_pulse_a)
    else
        $error("valid strobe held for more than one cycle");

    pulse_b_single: assert property (@(posedge ep50trig) disable iff (reset_global)
        i_pulse_b |=> !i_pulse_b)
    else
        $error("emg valid strobe held for more than one cycle");

endmodule

`default_nettype wire

/* test/tb_emg_core.sv */
`default_nettype none

module tb_emg_core;
    timeunit 1ns;
    timeprecision 1ps;
    import neuro_pkg::*;

    // test shape
    localparam int emg_runs = 4;
    localparam int emg_windows = 6;
    localparam int max_win = 100;
    localparam int sat_win = 1299;
    localparam int sat_windows = 3;
    localparam int sat_pulses = 300;
    // first rise of each line inside a window, in cycles
    localparam int sl_off = 6;
    localparam int ll_off = 8;

    logic ep50trig;
    logic reset_global;
    logic [addr_w-1:0] paddr;
    logic psel;
    logic penable;
    logic pwrite;
    logic [data_w-1:0] pwdata;
    logic [data_w-1:0] prdata;
    logic pready;
    logic pslverr;
    logic mn_spike;
    logic ll_spike;
    logic [emg_w-1:0] emg;
    logic emg_valid;

    int error_count;
    int check_count;
    // pulses driven per window, oldest first
    int sl_q[$];
    int ll_q[$];
    int windows_sent;
    int windows_checked;
    int run_windows;
    int cur_gain;
    int cur_leak;
    int win_len;
    logic [emg_w-1:0] emg_exp;

    emg_core_top dut (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_paddr      (paddr),
        .i_psel       (psel),
        .i_penable    (penable),
        .i_pwrite     (pwrite),
        .i_pwdata     (pwdata),
        .o_prdata     (prdata),
        .o_pready     (pready),
        .o_pslverr    (pslverr),
        .i_mn_spike   (mn_spike),
        .i_ll_spike   (ll_spike),
        .o_emg        (emg),
        .o_emg_valid  (emg_valid)
    );

    // apb slave ports, counter valid and emg valid all meet at the top
    bind emg_core_top emg_core_assert core_checks (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_psel       (i_psel),
        .i_penable    (i_penable),
        .i_pready     (o_pready),
        .i_pslverr    (o_pslverr),
        .i_pulse_a    (count_valid),
        .i_pulse_b    (o_emg_valid)
    );

    // 8 ns period
    initial ep50trig = 1'b0;
    always #4 ep50trig = ~ep50trig;

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    // counters clip at 255
    function automatic int clip_count(input int n);
        return (n > 255) ? 255 : n;
    endfunction

    // next emg from the previous one and the window's pulse counts
    function automatic logic [emg_w-1:0] emg_model(input logic [emg_w-1:0] prev,
                                                    input int sl_n, input int ll_n,
                                                    input int gain, input int shift);
        longint sum;
        longint nxt;
        longint top;
        sum = longint'(clip_count(sl_n)) + longint'(clip_count(ll_n));
        top = (longint'(1) << emg_w) - 1;
        nxt = longint'(prev) - (longint'(prev) >> shift) + sum * longint'(gain);
        if (nxt > top)
            nxt = top;
        return nxt[emg_w-1:0];
    endfunction

    // n pulses from cycle off, 2 high then 2 low
    function automatic logic pulse_level(input int c, input int off, input int n);
        return (c >= off) && (c < off + 4 * n) && (((c - off) % 4) < 2);
    endfunction

    ////////////////////////////////////////
    // apb and check helpers
    ////////////////////////////////////////

    task automatic check_value(input string name, input longint exp, input longint act);
        check_count++;
        assert (exp == act)
        else
        begin
            error_count++;
            $display("CHECK FAILED at %0d ns: %s expected %0d, actual %0d",
                     $time, name, exp, act);
        end
    endtask

    // called 1 ns after a rising edge, returns 1 ns after the closing edge
    task automatic apb_write(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data,
                             output logic err);
        paddr = addr;
        pwdata = data;
        pwrite = 1'b1;
        psel = 1'b1;
        penable = 1'b0;
        @(posedge ep50trig);
        #1;
        penable = 1'b1;
        @(negedge ep50trig);
        err = pslverr;
        @(posedge ep50trig);
        #1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic apb_read(input logic [addr_w-1:0] addr, output logic [data_w-1:0] data,
                            output logic err);
        paddr = addr;
        pwrite = 1'b0;
        psel = 1'b1;
        penable = 1'b0;
        @(posedge ep50trig);
        #1;
        penable = 1'b1;
        // mid access phase
        @(negedge ep50trig);
        data = prdata;
        err = pslverr;
        @(posedge ep50trig);
        #1;
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic read_check(input logic [addr_w-1:0] addr, input string name,
                              input longint exp);
        logic [data_w-1:0] val;
        logic err;
        apb_read(addr, val, err);
        check_value({name, " pslverr"}, 0, longint'(err));
        check_value(name, exp, longint'(val));
    endtask

    ////////////////////////////////////////
    // window stimulus
    ////////////////////////////////////////

    // program and enable, window 0 starts at the enabling edge
    task automatic start_run(input int w, input int gain, input int leak);
        logic err;
        win_len = w;
        cur_gain = gain;
        cur_leak = leak;
        emg_exp = '0;
        run_windows = 0;
        apb_write(reg_window, data_w'(w), err);
        apb_write(reg_gain, data_w'(gain), err);
        apb_write(reg_leak, data_w'(leak), err);
        apb_write(reg_ctrl, 32'd1, err);
    endtask

    // drain pending checks, then disable before the next tick
    task automatic end_run();
        logic err;
        wait (windows_checked == windows_sent);
        @(posedge ep50trig);
        #1;
        apb_write(reg_ctrl, 32'd0, err);
    endtask

    task automatic run_window(input int sl_n, input int ll_n);
        sl_q.push_back(sl_n);
        ll_q.push_back(ll_n);
        windows_sent++;
        for (int c = 0; c <= win_len; c++)
        begin
            mn_spike = pulse_level(c, sl_off, sl_n);
            ll_spike = pulse_level(c, ll_off, ll_n);
            @(posedge ep50trig);
            #1;
        end
    endtask

    // keeps every rise at least 6 cycles clear of both boundaries
    task automatic random_window();
        int n_max;
        n_max = (win_len - 16) / 4;
        run_window(int'($urandom_range(n_max)), int'($urandom_range(n_max)));
    endtask

    ////////////////////////////////////////
    // comparing process
    ////////////////////////////////////////

    initial
    begin : compare_results
        int sl_n;
        int ll_n;
        forever
        begin
            @(negedge ep50trig);
            if (emg_valid === 1'b1)
            begin
                assert (sl_q.size() > 0)
                else
                begin
                    error_count++;
                    $display("ERROR at %0d ns: o_emg_valid pulsed with no window pending",
                             $time);
                end
                if (sl_q.size() > 0)
                begin
                    sl_n = sl_q.pop_front();
                    ll_n = ll_q.pop_front();
                    // first window after enable starts from an empty integrator
                    if (run_windows == 0)
                        check_value("o_emg first window",
                                    longint'(cur_gain) * (clip_count(sl_n) + clip_count(ll_n)),
                                    longint'(emg));
                    emg_exp = emg_model(emg_exp, sl_n, ll_n, cur_gain, cur_leak);
                    check_value("o_emg", longint'(emg_exp), longint'(emg));
                    run_windows++;
                    @(posedge ep50trig);
                    #1;
                    read_check(reg_sl_count, "reg_sl_count", longint'(clip_count(sl_n)));
                    read_check(reg_ll_count, "reg_ll_count", longint'(clip_count(ll_n)));
                    read_check(reg_index, "reg_index", longint'(run_windows));
                    read_check(reg_emg, "reg_emg", longint'(emg_exp));
                    windows_checked++;
                end
            end
        end
    end

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial
    begin : main_sequence
        logic [data_w-1:0] win_val;
        logic [data_w-1:0] gain_val;
        logic [data_w-1:0] leak_val;
        logic [data_w-1:0] rdata;
        logic [addr_w-1:0] addr;
        logic err;
        void'($urandom(32'h0c462e57));
        error_count = 0;
        check_count = 0;
        windows_sent = 0;
        windows_checked = 0;
        run_windows = 0;
        cur_gain = 1;
        cur_leak = 2;
        win_len = 99;
        emg_exp = '0;
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = '0;
        mn_spike = 1'b0;
        ll_spike = 1'b0;
        reset_global = 1'b1;
        repeat (2) @(posedge ep50trig);
        #1;
        reset_global = 1'b0;

        // reset values
        read_check(reg_ctrl, "reg_ctrl", 0);
        read_check(reg_window, "reg_window", 99);
        read_check(reg_gain, "reg_gain", 1);
        read_check(reg_leak, "reg_leak", 2);
        read_check(reg_emg, "reg_emg", 0);
        read_check(reg_index, "reg_index", 0);
        // disabled, comparer flags any emg valid
        repeat (2 * (max_win + 1)) @(posedge ep50trig);
        #1;

        // enable bit alone, for a few cycles only
        apb_write(reg_ctrl, 32'hffff_ffff, err);
        read_check(reg_ctrl, "reg_ctrl", 1);
        apb_write(reg_ctrl, 32'hffff_fffe, err);
        read_check(reg_ctrl, "reg_ctrl", 0);
        for (int i = 0; i < 8; i++)
        begin
            win_val = $urandom();
            gain_val = $urandom();
            leak_val = $urandom();
            apb_write(reg_window, win_val, err);
            check_value("o_pslverr window write", 0, longint'(err));
            read_check(reg_window, "reg_window", longint'(win_val[win_w-1:0]));
            apb_write(reg_gain, gain_val, err);
            read_check(reg_gain, "reg_gain", longint'(gain_val[gain_w-1:0]));
            apb_write(reg_leak, leak_val, err);
            read_check(reg_leak, "reg_leak", longint'(leak_val[shift_w-1:0]));
        end
        // status registers refuse writes
        for (int i = 0; i < 4; i++)
        begin
            addr = 8'h10 + 8'(4 * i);
            apb_write(addr, $urandom(), err);
            check_value("o_pslverr read-only write", 1, longint'(err));
            read_check(addr, "read-only register", 0);
        end
        read_check(reg_window, "reg_window", longint'(win_val[win_w-1:0]));
        read_check(reg_gain, "reg_gain", longint'(gain_val[gain_w-1:0]));
        read_check(reg_leak, "reg_leak", longint'(leak_val[shift_w-1:0]));
        // unmapped space, above the map and off word alignment
        for (int i = 0; i < 6; i++)
        begin
            addr = (i < 3) ? 8'($urandom_range(255, 32)) : 8'(4 * i + 1);
            apb_read(addr, rdata, err);
            check_value("o_pslverr unmapped read", 1, longint'(err));
        end
        apb_write(8'h24, 32'd7, err);
        check_value("o_pslverr unmapped write", 1, longint'(err));

        // window counting and filter, random coefficients per run
        for (int r = 0; r < emg_runs; r++)
        begin
            start_run(40 + int'($urandom_range(max_win - 40)), int'($urandom_range(255)),
                      int'($urandom_range(15)));
            for (int k = 0; k < emg_windows; k++)
                random_window();
            end_run();
        end

        // count and emg saturation
        start_run(sat_win, 255, 15);
        for (int k = 0; k < sat_windows; k++)
            run_window(sat_pulses, sat_pulses);
        wait (windows_checked == windows_sent);
        check_value("o_emg saturated", longint'(emg_max), longint'(emg));
        end_run();

        // disable clears emg and index and stops updates
        repeat (2 * (max_win + 1)) @(posedge ep50trig);
        #1;
        read_check(reg_emg, "reg_emg", 0);
        read_check(reg_index, "reg_index", 0);
        start_run(60, int'($urandom_range(255)), int'($urandom_range(15)));
        random_window();
        random_window();
        end_run();

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

    // every window of every run plus a margin for register traffic
    initial
    begin : watchdog
        longint limit_cycles;
        limit_cycles = longint'((emg_runs * (emg_windows + 1) + 7) * (max_win + 1))
                     + longint'((sat_windows + 1) * (sat_win + 1)) + 2000;
        #(limit_cycles * 8);
        $display("timeout: run did not finish within %0d cycles", limit_cycles);
        $display("checks: %0d, errors: %0d", check_count, error_count + 1);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
